// ==== cpu_core.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_regfile.sv
cpu_execute.sv
cpu_mem_wb.sv
cpu_core.sv
cpu_core_assert.sv
cpu_core_tb.sv

// ==== cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	output word_t instr_addr,
	input  word_t instruction,
	output word_t address,
	output word_t writedata,
	output logic  wren,
	output logic  request,
	input  word_t readdata,
	input  logic  response
);

	logic       fetch_valid;
	fetch_out_t fetch_out;
	logic       dec_valid;
	dec_out_t   dec_out;
	logic       exe_valid;
	exe_out_t   exe_out;
	reg_code_t  rd_a_code;
	reg_code_t  rd_b_code;
	word_t      rd_a;
	word_t      rd_b;
	logic       wr_en;
	reg_code_t  wr_code;
	word_t      wr_data;
	logic       redirect;
	word_t      redirect_addr;
	logic       retire;

	cpu_fetch cpu_fetch_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.retire        (retire),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.instr_addr    (instr_addr),
		.instruction   (instruction),
		.fetch_valid   (fetch_valid),
		.fetch_out     (fetch_out)
	);

	cpu_decode cpu_decode_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.fetch_valid (fetch_valid),
		.fetch_out   (fetch_out),
		.dec_valid   (dec_valid),
		.dec_out     (dec_out)
	);

	// code 7 reads back the word address being executed
	cpu_regfile cpu_regfile_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_a_code (rd_a_code),
		.rd_b_code (rd_b_code),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.cur_addr  (instr_addr),
		.wr_en     (wr_en),
		.wr_code   (wr_code),
		.wr_data   (wr_data)
	);

	cpu_execute cpu_execute_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.dec_valid (dec_valid),
		.dec_out   (dec_out),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.rd_a_code (rd_a_code),
		.rd_b_code (rd_b_code),
		.exe_valid (exe_valid),
		.exe_out   (exe_out)
	);

	// port A still addresses op1 here, so it doubles as the merge read
	cpu_mem_wb cpu_mem_wb_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.exe_valid     (exe_valid),
		.exe_out       (exe_out),
		.address       (address),
		.writedata     (writedata),
		.wren          (wren),
		.request       (request),
		.readdata      (readdata),
		.response      (response),
		.wr_en         (wr_en),
		.wr_code       (wr_code),
		.wr_data       (wr_data),
		.rd_old        (rd_a),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.retire        (retire)
	);

endmodule

// ==== cpu_core_assert.sv ====
`timescale 1ns/1ps

module cpu_core_assert import cpu_isa_pkg::*; (
	input logic  clk,
	input logic  rst_n,
	input logic  request,
	input logic  wren,
	input word_t address,
	input word_t writedata,
	input logic  response
);

	int unsigned fail_count = 0;

	// port idle while reset is applied
	reset_idle: assert property (@(posedge clk) !rst_n |-> !request && !wren)
		else begin
			fail_count = fail_count + 1;
			$error("request or wren high during reset");
		end

	// first cycle out of reset
	release_idle: assert property (@(posedge clk) $rose(rst_n) |-> !request)
		else begin
			fail_count = fail_count + 1;
			$error("request high right after reset");
		end

	hold_until_response: assert property (@(posedge clk) disable iff (!rst_n)
		request && !response |=> request && $stable(address) &&
			$stable(writedata) && $stable(wren))
		else begin
			fail_count = fail_count + 1;
			$error("data port changed before response");
		end

	drop_after_response: assert property (@(posedge clk) disable iff (!rst_n)
		request && response |=> !request)
		else begin
			fail_count = fail_count + 1;
			$error("request still high after response");
		end

	wren_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
		wren |-> request)
		else begin
			fail_count = fail_count + 1;
			$error("wren high without request");
		end

endmodule

// ==== cpu_core_golden.txt ====
# I <word address> <instruction word>, M <address> <initial data word>
# W <store address> <store data>, stores listed in the order they happen
# long moves build constants, skipped immediate E000 would be a store
I 00 9A000040
I 01 98000001
I 02 90005678
I 03 A0001234
I 04 EA000B20
I 05 9000E000
I 06 EA000B20
# alu results with suffix, then a compare without it
I 07 9200F0F0
I 08 A2000F0F
I 09 84000460
I 0A EA800B20
I 0B 86002660
I 0C EAC00B20
I 0D 84003460
I 0E EA800B20
I 0F 86005660
I 10 2640EAC0
I 11 0B20F000
# overflowing add, then adc and flag moves
I 12 90000000
I 13 A0008000
I 14 9C00FFFF
I 15 AC007FFF
I 16 0020B400
I 17 1C20B600
I 18 EA800B20
I 19 EAC00B20
I 1A EB800B20
# loads then stores to new addresses
I 1B 526054A0
I 1C 92000010
I 1D D4400320
I 1E D640EA80
I 1F 0B20EAC0
I 20 0B20F000
# countdown loop, exit on zero
I 21 526054A0
I 22 90000003
I 23 94000027
I 24 83C0EA00
I 25 0B202120
I 26 C410C200
I 27 B600EAC0
I 28 8DC0CC00
M 10 CAFEF00D
M 11 0BADBEEF
W 40 12345678
W 41 1234E000
W 42 2144D0F0
W 43 0324EF10
W 44 0204E000
W 45 1D3B10F0
W 46 0000000D
W 47 00000006
W 48 80000000
W 49 CAFEF00D
W 4A 0BADBEEF
W 4B 00000003
W 4C 00000002
W 4D 00000001
W 4E 00000008

// ==== cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb import cpu_isa_pkg::*; ();

	localparam int MEM_WORDS = 256;
	localparam int QUIET_CYCLES = 20;

	logic        clk;
	logic        rst_n;
	word_t       instr_addr;
	word_t       instruction;
	word_t       address;
	word_t       writedata;
	logic        wren;
	logic        request;
	word_t       readdata = '0;
	logic        response = 1'b0;

	word_t       imem [0:MEM_WORDS-1];
	word_t       dmem [0:MEM_WORDS-1];
	word_t       exp_addr_q [$];
	word_t       exp_data_q [$];
	int          prog_words = 0;
	int          timeout_limit = 0;
	int          cycle_count = 0;
	int          wait_left = 0;
	logic        busy = 1'b0;
	logic [31:0] rng_state = 32'h6de4_be5d;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// combinational instruction read within the cycle
	assign instruction = (instr_addr < MEM_WORDS) ? imem[instr_addr[7:0]] : '1;

	cpu_core cpu_core_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_addr  (instr_addr),
		.instruction (instruction),
		.address     (address),
		.writedata   (writedata),
		.wren        (wren),
		.request     (request),
		.readdata    (readdata),
		.response    (response)
	);

	bind cpu_core cpu_core_assert cpu_core_assert_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.request   (request),
		.wren      (wren),
		.address   (address),
		.writedata (writedata),
		.response  (response)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			stop_with_failure($sformatf("ERROR %s exp %h got %h", name, exp, got));
		end
	endtask

	task automatic check_store(input word_t addr, input word_t data);
		if (exp_addr_q.size() == 0) begin
			stop_with_failure($sformatf("store to %h while no store was expected", addr));
		end else begin
			check_word("address", exp_addr_q.pop_front(), addr);
			check_word("writedata", exp_data_q.pop_front(), data);
		end
	endtask

	// one access served in the current cycle
	task automatic serve_access();
		if (address >= MEM_WORDS) begin
			stop_with_failure($sformatf("data access outside memory at %h", address));
		end else if (wren) begin
			check_store(address, writedata);
			dmem[address[7:0]] = writedata;
			response <= 1'b1;
		end else begin
			readdata <= dmem[address[7:0]];
			response <= 1'b1;
		end
	endtask

	task automatic read_golden();
		int    fd;
		int    n;
		string line;
		byte   kind;
		word_t a;
		word_t d;
		fd = $fopen("cpu_core_golden.txt", "r");
		if (fd == 0) begin
			stop_with_failure("could not open cpu_core_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 2 && line.getc(0) != "#") begin
					kind = line.getc(0);
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
					if (n != 2 || a >= MEM_WORDS) begin
						stop_with_failure({"unreadable line in golden file: ", line});
					end else begin
						case (kind)
							"I": begin
								imem[a[7:0]] = d;
								prog_words++;
							end
							"M": dmem[a[7:0]] = d;
							"W": begin
								exp_addr_q.push_back(a);
								exp_data_q.push_back(d);
							end
							default: stop_with_failure({"unknown record in golden file: ", line});
						endcase
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// data memory with 0 to 3 idle cycles before each response
	always @(posedge clk) begin
		if (!rst_n) begin
			response <= 1'b0;
			busy <= 1'b0;
			wait_left <= 0;
		end else if (response) begin
			response <= 1'b0;
			busy <= 1'b0;
		end else if (request && !busy) begin
			rng_state = xorshift32(rng_state);
			busy <= 1'b1;
			wait_left <= int'(rng_state[1:0]);
			if (rng_state[1:0] == 2'd0) begin
				serve_access();
			end
		end else if (busy && wait_left > 0) begin
			wait_left <= wait_left - 1;
			if (wait_left == 1) begin
				serve_access();
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cpu_core_inst.cpu_core_assert_inst.fail_count != 0) begin
			stop_with_failure("a data port assertion failed");
		end else if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
		end
	end

	initial begin
		rst_n = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			// unused words decode as NOP
			imem[i] = {4'hF, 4'h0, 8'(i), 4'hF, 4'h0, 8'(~i)};
			dmem[i] = {8'hDA, 8'(i), 8'(~i), 8'(i * 7)};
		end
		read_golden();
		// two halves per word and room for a slow access on each
		timeout_limit = prog_words * 2 * (4 + 4) + 100;
		repeat (4) @(posedge clk);
		check_word("instr_addr", '0, instr_addr);
		rst_n <= 1'b1;
		while (exp_addr_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (QUIET_CYCLES) @(posedge clk);
		if (cpu_core_inst.cpu_core_assert_inst.fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure("a data port assertion failed");
		end
	end

endmodule

// ==== cpu_decode.sv ====
`timescale 1ns/1ps

module cpu_decode import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       fetch_valid,
	input  fetch_out_t fetch_out,
	output logic       dec_valid,
	output dec_out_t   dec_out
);

	opcode_t  raw_op;
	logic     long_move;
	dec_out_t dec_nxt;

	assign raw_op = opcode_t'(fetch_out.instr[15:12]);
	assign long_move = raw_op inside {MOVL, MOVH};

	always_comb begin
		dec_nxt.op1 = fetch_out.instr[11:9];
		dec_nxt.op2 = fetch_out.instr[8:6];
		dec_nxt.suffix = fetch_out.instr[5];
		dec_nxt.cond = cond_t'(fetch_out.instr[5:4]);

		// a long move needs the lower half as its immediate,
		// so one sitting in the lower half has nothing to take
		if (long_move && fetch_out.lower) begin
			dec_nxt.op = NOP;
		end else begin
			dec_nxt.op = raw_op;
		end

		if (long_move) begin
			dec_nxt.imm = fetch_out.ext;
		end else begin
			dec_nxt.imm = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			dec_out <= '{
				op: NOP,
				op1: '0,
				op2: '0,
				suffix: 1'b0,
				cond: ALWAYS,
				imm: '0
			};
		end else begin
			dec_valid <= fetch_valid;
			// fields stay put until the next issue
			if (fetch_valid) begin
				dec_out <= dec_nxt;
			end
		end
	end

endmodule

// ==== cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data word and address width
`define CPU_WIDTH 32

// one instruction or immediate
`define CPU_HALF 16

// register code width, code 7 is the instruction pointer
`define CPU_REG_BITS 3

// flags word
`define CPU_FLAGS 4
`define CPU_FLAG_C 0
`define CPU_FLAG_S 1
`define CPU_FLAG_O 2
`define CPU_FLAG_Z 3

`endif

// ==== cpu_execute.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_execute import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      dec_valid,
	input  dec_out_t  dec_out,
	input  word_t     rd_a,
	input  word_t     rd_b,
	output reg_code_t rd_a_code,
	output reg_code_t rd_b_code,
	output logic      exe_valid,
	output exe_out_t  exe_out
);

	localparam int MSB = `CPU_WIDTH - 1;

	flags_t                flags_q;
	flags_t                flags_nxt;
	logic                  alu_op;
	logic                  carry_in;
	logic                  take;
	logic [`CPU_WIDTH:0]   sum;
	word_t                 alu_res;
	exe_out_t              exe_nxt;

	// port A stays on op1 through writeback for half-word merges
	assign rd_a_code = dec_out.op1;
	assign rd_b_code = dec_out.op2;

	assign alu_op = dec_out.op inside {[ADD:SHR]};
	assign carry_in = (dec_out.op == ADC) ? flags_q[`CPU_FLAG_C] : 1'b0;
	// top bit is carry out, or borrow for SUB
	assign sum = (dec_out.op == SUB) ? {1'b0, rd_a} - {1'b0, rd_b} :
		{1'b0, rd_a} + {1'b0, rd_b} + {{`CPU_WIDTH{1'b0}}, carry_in};

	always_comb begin
		alu_res = '0;
		flags_nxt = flags_q;
		case (dec_out.op)
			ADD, ADC, SUB: begin
				alu_res = sum[MSB:0];
				flags_nxt[`CPU_FLAG_C] = sum[`CPU_WIDTH];
				if (dec_out.op == SUB) begin
					flags_nxt[`CPU_FLAG_O] = (rd_a[MSB] != rd_b[MSB]) &&
						(alu_res[MSB] != rd_a[MSB]);
				end else begin
					flags_nxt[`CPU_FLAG_O] = (rd_a[MSB] == rd_b[MSB]) &&
						(alu_res[MSB] != rd_a[MSB]);
				end
			end
			AND, OR, XOR: begin
				if (dec_out.op == AND) begin
					alu_res = rd_a & rd_b;
				end else if (dec_out.op == OR) begin
					alu_res = rd_a | rd_b;
				end else begin
					alu_res = rd_a ^ rd_b;
				end
				flags_nxt[`CPU_FLAG_C] = 1'b0;
				flags_nxt[`CPU_FLAG_O] = 1'b0;
			end
			SHL: begin
				alu_res = rd_b << 1;
				flags_nxt[`CPU_FLAG_C] = rd_b[MSB];
				flags_nxt[`CPU_FLAG_O] = 1'b0;
			end
			SHR: begin
				alu_res = rd_b >> 1;
				flags_nxt[`CPU_FLAG_C] = rd_b[0];
				flags_nxt[`CPU_FLAG_O] = 1'b0;
			end
			default: begin
				alu_res = '0;
			end
		endcase
		flags_nxt[`CPU_FLAG_S] = alu_res[MSB];
		flags_nxt[`CPU_FLAG_Z] = (alu_res == '0);
	end

	// jump condition against flags left by earlier instructions
	always_comb begin
		case (dec_out.cond)
			ALWAYS: take = 1'b1;
			ZERO: take = flags_q[`CPU_FLAG_Z];
			CARRY: take = flags_q[`CPU_FLAG_C];
			default: take = flags_q[`CPU_FLAG_S];
		endcase
	end

	always_comb begin
		exe_nxt = '0;
		exe_nxt.dest = dec_out.op1;
		case (dec_out.op)
			MOVR: begin
				exe_nxt.we = 1'b1;
				exe_nxt.result = rd_b;
			end
			MOVL: begin
				exe_nxt.we = 1'b1;
				exe_nxt.result = {{`CPU_HALF{1'b0}}, dec_out.imm};
				exe_nxt.part = PART_LOW;
			end
			MOVH: begin
				exe_nxt.we = 1'b1;
				exe_nxt.result = {dec_out.imm, {`CPU_HALF{1'b0}}};
				exe_nxt.part = PART_HIGH;
			end
			MOVF: begin
				exe_nxt.we = 1'b1;
				exe_nxt.result = word_t'(flags_q);
			end
			JMP: begin
				exe_nxt.jump = take;
				exe_nxt.result = rd_a;
			end
			LOAD: begin
				exe_nxt.we = 1'b1;
				exe_nxt.mem_req = 1'b1;
				exe_nxt.addr = rd_b;
			end
			STORE: begin
				exe_nxt.mem_req = 1'b1;
				exe_nxt.mem_we = 1'b1;
				exe_nxt.addr = rd_a;
				exe_nxt.data = rd_b;
			end
			NOP: begin
				exe_nxt.we = 1'b0;
			end
			default: begin
				// ALU ops write back only with the suffix
				exe_nxt.we = dec_out.suffix;
				exe_nxt.result = alu_res;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exe_valid <= 1'b0;
			flags_q <= '0;
		end else begin
			exe_valid <= dec_valid;
			if (dec_valid && alu_op) begin
				flags_q <= flags_nxt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			exe_out <= exe_nxt;
		end
	end

endmodule

// ==== cpu_fetch.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_fetch import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       retire,
	input  logic       redirect,
	input  word_t      redirect_addr,
	output word_t      instr_addr,
	input  word_t      instruction,
	output logic       fetch_valid,
	output fetch_out_t fetch_out
);

	logic  half_lo;
	logic  started;
	logic  cur_long;
	word_t instr_addr_q;

	assign instr_addr = instr_addr_q;

	// long move in the upper half consumes the whole word
	assign cur_long = !half_lo &&
		(opcode_t'(instruction[`CPU_WIDTH-1 -: 4]) inside {MOVL, MOVH});

	always_comb begin
		fetch_out.instr = half_lo ? instruction[`CPU_HALF-1:0] :
			instruction[`CPU_WIDTH-1:`CPU_HALF];
		fetch_out.addr = instr_addr_q;
		fetch_out.lower = half_lo;
		fetch_out.ext = instruction[`CPU_HALF-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			instr_addr_q <= '0;
			half_lo <= 1'b0;
			started <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			// first issue right after reset, then one per retire
			fetch_valid <= retire || !started;
			started <= 1'b1;
			if (redirect) begin
				instr_addr_q <= redirect_addr;
				half_lo <= 1'b0;
			end else if (retire) begin
				if (half_lo || cur_long) begin
					instr_addr_q <= instr_addr_q + 1'b1;
					half_lo <= 1'b0;
				end else begin
					half_lo <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	`include "cpu_defines.svh"

	typedef logic [`CPU_WIDTH-1:0] word_t;
	typedef logic [`CPU_HALF-1:0] half_t;
	typedef logic [`CPU_REG_BITS-1:0] reg_code_t;
	typedef logic [`CPU_FLAGS-1:0] flags_t;

	// instruction bits 15..12
	typedef enum logic [3:0] {
		ADD   = 4'd0,
		ADC   = 4'd1,
		SUB   = 4'd2,
		AND   = 4'd3,
		OR    = 4'd4,
		XOR   = 4'd5,
		SHL   = 4'd6,
		SHR   = 4'd7,
		MOVR  = 4'd8,
		MOVL  = 4'd9,
		MOVH  = 4'd10,
		MOVF  = 4'd11,
		JMP   = 4'd12,
		LOAD  = 4'd13,
		STORE = 4'd14,
		NOP   = 4'd15
	} opcode_t;

	// jump condition, bits 5..4 of JMP
	typedef enum logic [1:0] {
		ALWAYS = 2'd0,
		ZERO   = 2'd1,
		CARRY  = 2'd2,
		SIGN   = 2'd3
	} cond_t;

	// reads give the current word address, writes redirect fetch
	localparam reg_code_t IP_CODE = 3'd7;

endpackage

// ==== cpu_mem_wb.sv ====
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_mem_wb import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      exe_valid,
	input  exe_out_t  exe_out,
	output word_t     address,
	output word_t     writedata,
	output logic      wren,
	output logic      request,
	input  word_t     readdata,
	input  logic      response,
	output logic      wr_en,
	output reg_code_t wr_code,
	output word_t     wr_data,
	input  word_t     rd_old,
	output logic      redirect,
	output word_t     redirect_addr,
	output logic      retire
);

	wb_state_t state;
	word_t     merged;
	logic      ip_write;

	// half-word moves keep the other half of the destination
	always_comb begin
		case (exe_out.part)
			PART_LOW: merged = {rd_old[`CPU_WIDTH-1:`CPU_HALF], exe_out.result[`CPU_HALF-1:0]};
			PART_HIGH: merged = {exe_out.result[`CPU_WIDTH-1:`CPU_HALF], rd_old[`CPU_HALF-1:0]};
			default: merged = exe_out.result;
		endcase
	end

	assign ip_write = exe_out.we && exe_out.dest == IP_CODE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			address <= '0;
			writedata <= '0;
			wren <= 1'b0;
			request <= 1'b0;
			wr_en <= 1'b0;
			wr_code <= '0;
			wr_data <= '0;
			redirect <= 1'b0;
			redirect_addr <= '0;
			retire <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			redirect <= 1'b0;
			retire <= 1'b0;
			case (state)
				IDLE: begin
					if (exe_valid && exe_out.mem_req) begin
						request <= 1'b1;
						wren <= exe_out.mem_we;
						address <= exe_out.addr;
						writedata <= exe_out.data;
						wr_code <= exe_out.dest;
						state <= MEM_WAIT;
					end else if (exe_valid) begin
						wr_en <= exe_out.we && !ip_write;
						wr_code <= exe_out.dest;
						wr_data <= merged;
						redirect <= ip_write || exe_out.jump;
						redirect_addr <= exe_out.jump ? exe_out.result : merged;
						retire <= 1'b1;
					end
				end
				MEM_WAIT: begin
					// access held until the memory answers
					if (response) begin
						request <= 1'b0;
						wren <= 1'b0;
						retire <= 1'b1;
						if (!wren) begin
							wr_en <= wr_code != IP_CODE;
							wr_data <= readdata;
							redirect <= wr_code == IP_CODE;
							redirect_addr <= readdata;
						end
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

	import cpu_isa_pkg::*;

	typedef enum logic [1:0] {
		PART_NONE = 2'd0,
		PART_LOW  = 2'd1,
		PART_HIGH = 2'd2
	} part_sel_t;

	typedef struct packed {
		half_t instr;
		word_t addr;
		// set when instr is the lower half of the word
		logic  lower;
		// lower half, immediate of a long move
		half_t ext;
	} fetch_out_t;

	typedef struct packed {
		opcode_t   op;
		reg_code_t op1;
		reg_code_t op2;
		logic      suffix;
		cond_t     cond;
		half_t     imm;
	} dec_out_t;

	typedef struct packed {
		logic      we;
		reg_code_t dest;
		word_t     result;
		part_sel_t part;
		logic      mem_req;
		logic      mem_we;
		word_t     addr;
		word_t     data;
		logic      jump;
	} exe_out_t;

	typedef enum logic {
		IDLE     = 1'b0,
		MEM_WAIT = 1'b1
	} wb_state_t;

endpackage

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile import cpu_isa_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_code_t rd_a_code,
	input  reg_code_t rd_b_code,
	output word_t     rd_a,
	output word_t     rd_b,
	input  word_t     cur_addr,
	input  logic      wr_en,
	input  reg_code_t wr_code,
	input  word_t     wr_data
);

	// r0..r5 plus the stack pointer in r6
	word_t regs [0:6];

	assign rd_a = (rd_a_code == IP_CODE) ? cur_addr : regs[rd_a_code];
	assign rd_b = (rd_b_code == IP_CODE) ? cur_addr : regs[rd_b_code];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 7; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_code != IP_CODE) begin
			regs[wr_code] <= wr_data;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_core_tb -f cpu_core.f -o cpu_core_sim

result=$(./obj_dir/cpu_core_sim +verilator+error+limit+1000 || true)
echo "$result"
echo "$result" | grep -q "TEST RESULT: PASS"
